/* common/elevator_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Shared elevator definitions
// Floor count, floor index and per-floor mask types
// Button bank and queue request structs
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package elevator_pkg;

    // Floors served by the car
    localparam int num_floors = 11;

    // Floor index, 0 is the first floor
    typedef logic [3:0] floor_t;

    // One bit per floor, bit i is floor i
    typedef logic [num_floors-1:0] floor_mask_t;

    ////////////////////////////////////////////////////////////////////////
    // Structs
    ////////////////////////////////////////////////////////////////////////

    // Hall calls and car panel buttons, used for buttons and lamps alike
    typedef struct packed {
        floor_mask_t call;
        floor_mask_t panel;
    } button_bank_t;

    // One-cycle push into the request queue
    typedef struct packed {
        logic   valid;
        floor_t floor;
    } request_t;

endpackage

`default_nettype wire

/* requests/request_latch.sv */
////////////////////////////////////////////////////////////////////////////
// Request latch
// Samples hall and panel buttons, holds the 22 lamp flip-flops
// and generates at most one queue push per cycle
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module request_latch (
    input  wire logic                       clock,
    input  wire logic                       reset_n,
    input  wire elevator_pkg::button_bank_t buttons,
    input  wire elevator_pkg::floor_t       current_floor,
    input  wire logic                       power_switch,
    input  wire logic                       emergency_btn,
    input  wire logic                       full,
    input  wire logic                       arrived,
    output elevator_pkg::request_t          push,
    output elevator_pkg::button_bank_t      lights
);
    import elevator_pkg::*;

    floor_mask_t  at_floor;
    floor_mask_t  clear_mask;
    floor_mask_t  call_pick;
    floor_mask_t  panel_pick;
    button_bank_t eligible;
    button_bank_t lights_next;
    logic         accept_enable;

    // Isolate the lowest set bit
    function automatic floor_mask_t lowest_set(input floor_mask_t mask);
        return mask & floor_mask_t'(~mask + 1'b1);
    endfunction

    // Index of the single set bit of a one-hot mask
    function automatic floor_t mask_index(input floor_mask_t one_hot);
        floor_t idx;
        idx = '0;
        for (int i = 0; i < num_floors; i++) begin
            if (one_hot[i]) begin
                idx = floor_t'(i);
            end
        end
        return idx;
    endfunction

    ////////////////////////////////////////////////////////////////////////
    // Acceptance
    ////////////////////////////////////////////////////////////////////////

    // Decode of the car position
    always_comb begin
        for (int i = 0; i < num_floors; i++) begin
            at_floor[i] = (current_floor == floor_t'(i));
        end
    end

    assign accept_enable = power_switch && !emergency_btn && !full;

    // Pressed, unlit and not at the car's own floor
    always_comb begin
        eligible = '0;
        if (accept_enable) begin
            eligible.call  = buttons.call & ~lights.call & ~at_floor;
            eligible.panel = buttons.panel & ~lights.panel & ~at_floor;
        end
    end

    // Hall calls win, panel only when no call is eligible
    always_comb begin
        call_pick  = lowest_set(eligible.call);
        panel_pick = (call_pick == '0) ? lowest_set(eligible.panel) : '0;
    end

    assign push.valid = |(call_pick | panel_pick);
    assign push.floor = mask_index(call_pick | panel_pick);

    ////////////////////////////////////////////////////////////////////////
    // Lamps
    ////////////////////////////////////////////////////////////////////////

    // Arrival clears both lamps of the floor reached
    assign clear_mask = arrived ? at_floor : '0;

    always_comb begin
        lights_next.call  = (lights.call & ~clear_mask) | call_pick;
        lights_next.panel = (lights.panel & ~clear_mask) | panel_pick;
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            lights <= '0;
        end else begin
            lights <= lights_next;
        end
    end

    // Never more than one lamp lights up on a single edge
    a_one_new_lamp: assert property (
        @(posedge clock) disable iff (!reset_n)
        $onehot0(lights & ~$past(lights))
    );

endmodule

`default_nettype wire

/* requests/request_queue.sv */
////////////////////////////////////////////////////////////////////////////
// Request queue
// Circular FIFO of pending target floors, oldest entry shown on head
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module request_queue #(
    parameter int QUEUE_DEPTH = 16
) (
    input  wire logic                   clock,
    input  wire logic                   reset_n,
    input  wire elevator_pkg::request_t push,
    input  wire logic                   pop,
    output elevator_pkg::floor_t        head,
    output logic                        empty,
    output logic                        full
);
    import elevator_pkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] count_t;

    floor_t entries [QUEUE_DEPTH];
    ptr_t   wr_ptr;
    ptr_t   rd_ptr;
    count_t count;
    logic   do_push;
    logic   do_pop;

    // Step a pointer around the ring
    function automatic ptr_t ptr_next(input ptr_t ptr);
        if (ptr == ptr_t'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign empty   = (count == '0);
    assign full    = (count == count_t'(QUEUE_DEPTH));
    assign do_push = push.valid && !full;
    assign do_pop  = pop && !empty;

    // Oldest pending floor
    assign head = entries[rd_ptr];

    ////////////////////////////////////////////////////////////////////////
    // Storage and pointers
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (do_push) begin
            entries[wr_ptr] <= push.floor;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            // Simultaneous push and pop keeps the count
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Request latch must hold back while the queue is full
    a_no_push_full: assert property (
        @(posedge clock) disable iff (!reset_n)
        push.valid |-> !full
    );

    // Arrival only ever pops a real entry
    a_no_pop_empty: assert property (
        @(posedge clock) disable iff (!reset_n)
        pop |-> !empty
    );

endmodule

`default_nettype wire

/* logic/car_control.sv */
////////////////////////////////////////////////////////////////////////////
// Car control
// Target floor, direction, activation, arrival and door gating
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module car_control (
    input  wire elevator_pkg::floor_t head,
    input  wire logic                 empty,
    input  wire elevator_pkg::floor_t current_floor,
    input  wire logic                 elevator_moving,
    input  wire logic                 power_switch,
    input  wire logic                 emergency_btn,
    input  wire logic                 door_open_btn,
    input  wire logic                 door_close_btn,
    output logic                      arrived,
    output elevator_pkg::floor_t      elevator_floor_selector,
    output logic                      direction_selector,
    output logic                      activate_elevator,
    output logic                      door_open_allowed,
    output logic                      door_close_allowed
);

    logic car_idle;
    logic at_head;

    // Powered and standing still
    assign car_idle = power_switch && !elevator_moving;

    // Head is only meaningful with a pending entry
    assign at_head = !empty && (head == current_floor);

    ////////////////////////////////////////////////////////////////////////
    // Target and motion
    ////////////////////////////////////////////////////////////////////////

    assign elevator_floor_selector = empty ? '0 : head;

    // Arrival still completes during an emergency stop
    assign arrived = car_idle && at_head;

    assign activate_elevator = car_idle && !emergency_btn && !empty && !at_head;

    // Up when the target lies above, held low unless a move is requested
    assign direction_selector = activate_elevator && (head > current_floor);

    ////////////////////////////////////////////////////////////////////////
    // Doors
    ////////////////////////////////////////////////////////////////////////

    assign door_open_allowed  = car_idle && door_open_btn;
    assign door_close_allowed = car_idle && door_close_btn;

    // A stop at the target and a departure cannot coincide
    always_comb begin
        assert (!(arrived && activate_elevator))
            else $error("arrived and activate_elevator both high");
    end

endmodule

`default_nettype wire

/* logic/floor_logic_top.sv */
////////////////////////////////////////////////////////////////////////////
// Floor logic top level
// Request latch, request FIFO and car control, queue depth set here
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module floor_logic_top #(
    parameter int QUEUE_DEPTH = 16
) (
    input  wire logic                       clock,
    input  wire logic                       reset_n,
    input  wire elevator_pkg::button_bank_t buttons,
    input  wire logic                       door_open_btn,
    input  wire logic                       door_close_btn,
    input  wire logic                       emergency_btn,
    input  wire logic                       power_switch,
    input  wire elevator_pkg::floor_t       current_floor,
    input  wire logic                       elevator_moving,
    output elevator_pkg::button_bank_t      lights,
    output elevator_pkg::floor_t            elevator_floor_selector,
    output logic                            direction_selector,
    output logic                            activate_elevator,
    output logic                            door_open_allowed,
    output logic                            door_close_allowed
);
    import elevator_pkg::*;

    request_t push;
    floor_t   head;
    logic     empty;
    logic     full;
    logic     arrived;

    // Buttons in, lamps and pushes out
    request_latch request_latch_inst (
        .clock         (clock),
        .reset_n       (reset_n),
        .buttons       (buttons),
        .current_floor (current_floor),
        .power_switch  (power_switch),
        .emergency_btn (emergency_btn),
        .full          (full),
        .arrived       (arrived),
        .push          (push),
        .lights        (lights)
    );

    // Arrival retires the head entry
    request_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) request_queue_inst (
        .clock   (clock),
        .reset_n (reset_n),
        .push    (push),
        .pop     (arrived),
        .head    (head),
        .empty   (empty),
        .full    (full)
    );

    car_control car_control_inst (
        .head                    (head),
        .empty                   (empty),
        .current_floor           (current_floor),
        .elevator_moving         (elevator_moving),
        .power_switch            (power_switch),
        .emergency_btn           (emergency_btn),
        .door_open_btn           (door_open_btn),
        .door_close_btn          (door_close_btn),
        .arrived                 (arrived),
        .elevator_floor_selector (elevator_floor_selector),
        .direction_selector      (direction_selector),
        .activate_elevator       (activate_elevator),
        .door_open_allowed       (door_open_allowed),
        .door_close_allowed      (door_close_allowed)
    );

endmodule

`default_nettype wire

/* dv/floor_logic_model.svh */
////////////////////////////////////////////////////////////////////////////
// Reference model for the floor logic testbench
// Lamp masks, ordered request queue and expected control outputs
////////////////////////////////////////////////////////////////////////////

`ifndef FLOOR_LOGIC_MODEL_SVH
`define FLOOR_LOGIC_MODEL_SVH

// Model state, updated once per clock edge
logic [num_floors-1:0] model_call_lamps;
logic [num_floors-1:0] model_panel_lamps;
int                    model_queue[$];
int                    model_depth;

function automatic void model_reset(input int depth);
    model_call_lamps  = '0;
    model_panel_lamps = '0;
    model_queue.delete();
    model_depth = depth;
endfunction

// Oldest pending floor, 0 when nothing waits
function automatic int model_head();
    return (model_queue.size() > 0) ? model_queue[0] : 0;
endfunction

function automatic bit model_arrival(input int cur, input bit power, input bit moving);
    return power && !moving && (model_queue.size() > 0) && (model_queue[0] == cur);
endfunction

function automatic bit model_activation(input int cur, input bit power, input bit emergency,
                                        input bit moving);
    return power && !emergency && !moving && (model_queue.size() > 0)
        && (model_queue[0] != cur);
endfunction

// One clock edge: pick one request, retire the head on arrival
function automatic void model_advance(input logic [num_floors-1:0] calls,
                                      input logic [num_floors-1:0] panels,
                                      input int cur, input bit power, input bit emergency,
                                      input bit moving, output bit accepted, output bit popped);
    int chosen;
    bit chosen_call;
    chosen      = -1;
    chosen_call = 1'b0;
    if (power && !emergency && (model_queue.size() < model_depth)) begin
        for (int i = 0; i < num_floors; i++) begin
            if (chosen < 0 && calls[i] && !model_call_lamps[i] && i != cur) begin
                chosen      = i;
                chosen_call = 1'b1;
            end
        end
        for (int i = 0; i < num_floors; i++) begin
            if (chosen < 0 && panels[i] && !model_panel_lamps[i] && i != cur) begin
                chosen = i;
            end
        end
    end
    popped = model_arrival(cur, power, moving);
    if (popped) begin
        void'(model_queue.pop_front());
        model_call_lamps[cur]  = 1'b0;
        model_panel_lamps[cur] = 1'b0;
    end
    accepted = (chosen >= 0);
    if (accepted) begin
        model_queue.push_back(chosen);
        if (chosen_call) begin
            model_call_lamps[chosen] = 1'b1;
        end else begin
            model_panel_lamps[chosen] = 1'b1;
        end
    end
endfunction

`endif

/* dv/floor_logic_tb.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for the floor logic top level
// Seeded random buttons and car status, compared each cycle with a model
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module floor_logic_tb;
    import elevator_pkg::*;

    localparam int CLOCK_PERIOD = 40;
    localparam int NUM_CYCLES   = 4000;
    localparam int TEST_DEPTH   = 4;

    logic         clock;
    logic         reset_n;
    button_bank_t buttons;
    logic         door_open_btn;
    logic         door_close_btn;
    logic         emergency_btn;
    logic         power_switch;
    floor_t       current_floor;
    logic         elevator_moving;
    button_bank_t lights;
    floor_t       elevator_floor_selector;
    logic         direction_selector;
    logic         activate_elevator;
    logic         door_open_allowed;
    logic         door_close_allowed;

    int error_count;
    int accepted_count;
    int arrival_count;
    int full_cycles;

    `include "floor_logic_model.svh"

    floor_logic_top #(
        .QUEUE_DEPTH (TEST_DEPTH)
    ) floor_logic_top_inst (
        .clock                   (clock),
        .reset_n                 (reset_n),
        .buttons                 (buttons),
        .door_open_btn           (door_open_btn),
        .door_close_btn          (door_close_btn),
        .emergency_btn           (emergency_btn),
        .power_switch            (power_switch),
        .current_floor           (current_floor),
        .elevator_moving         (elevator_moving),
        .lights                  (lights),
        .elevator_floor_selector (elevator_floor_selector),
        .direction_selector      (direction_selector),
        .activate_elevator       (activate_elevator),
        .door_open_allowed       (door_open_allowed),
        .door_close_allowed      (door_close_allowed)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    // Run length plus margin, reset cycles included
    initial begin
        #((NUM_CYCLES + 100) * CLOCK_PERIOD);
        $display("Watchdog expired before the test sequence completed");
        $display("Simulation FAILED");
        $fatal(1, "watchdog timeout");
    end

    task automatic check_value(input string name, input int unsigned actual,
                               input int unsigned expected);
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %0t ns %s: got 0x%0h, expected 0x%0h", $time, name, actual,
                     expected);
            $display("Simulation FAILED");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic drive_random_inputs();
        int presses;
        int idx;
        buttons = '0;
        if ($urandom_range(99) < 45) begin
            presses = int'($urandom_range(3, 1));
            for (int n = 0; n < presses; n++) begin
                idx = int'($urandom_range(num_floors - 1));
                if ($urandom_range(1) == 1) begin
                    buttons.call[idx] = 1'b1;
                end else begin
                    buttons.panel[idx] = 1'b1;
                end
            end
        end
        // Steer the car to the target now and then so arrivals happen
        if (model_queue.size() > 0 && $urandom_range(99) < 25) begin
            current_floor = floor_t'(model_queue[0]);
        end else if ($urandom_range(99) < 20) begin
            current_floor = floor_t'($urandom_range(num_floors - 1));
        end
        elevator_moving = ($urandom_range(99) < 30);
        power_switch    = ($urandom_range(99) >= 4);
        emergency_btn   = ($urandom_range(99) < 5);
        door_open_btn   = 1'($urandom_range(1));
        door_close_btn  = 1'($urandom_range(1));
    endtask

    task automatic compare_outputs();
        int cur;
        bit exp_activate;
        bit exp_direction;
        bit idle;
        cur           = int'(current_floor);
        idle          = power_switch && !elevator_moving;
        exp_activate  = model_activation(cur, power_switch, emergency_btn, elevator_moving);
        exp_direction = exp_activate && (model_head() > cur);
        check_value("lights.call", 32'(lights.call), 32'(model_call_lamps));
        check_value("lights.panel", 32'(lights.panel), 32'(model_panel_lamps));
        check_value("elevator_floor_selector", 32'(elevator_floor_selector), model_head());
        check_value("activate_elevator", 32'(activate_elevator), 32'(exp_activate));
        check_value("direction_selector", 32'(direction_selector), 32'(exp_direction));
        check_value("door_open_allowed", 32'(door_open_allowed), 32'(idle && door_open_btn));
        check_value("door_close_allowed", 32'(door_close_allowed), 32'(idle && door_close_btn));
    endtask

    initial begin
        bit accepted;
        bit popped;
        reset_n         = 1'b0;
        buttons         = '0;
        door_open_btn   = 1'b0;
        door_close_btn  = 1'b0;
        emergency_btn   = 1'b0;
        power_switch    = 1'b1;
        current_floor   = '0;
        elevator_moving = 1'b0;
        error_count     = 0;
        accepted_count  = 0;
        arrival_count   = 0;
        full_cycles     = 0;
        void'($urandom(36));
        model_reset(TEST_DEPTH);

        // Powered and stopped, so only the empty queue keeps the car idle
        @(posedge clock);
        #18;
        compare_outputs();
        @(posedge clock);
        #2;
        reset_n = 1'b1;

        for (int cycle = 0; cycle < NUM_CYCLES; cycle++) begin
            drive_random_inputs();
            #(CLOCK_PERIOD - 4);
            compare_outputs();
            if (model_queue.size() == TEST_DEPTH) begin
                full_cycles++;
            end
            model_advance(buttons.call, buttons.panel, int'(current_floor), power_switch,
                          emergency_btn, elevator_moving, accepted, popped);
            accepted_count += int'(accepted);
            arrival_count  += int'(popped);
            @(posedge clock);
            #2;
        end

        if (accepted_count == 0 || arrival_count == 0 || full_cycles == 0) begin
            $display("Stimulus never reached a request, an arrival or a full queue");
            error_count++;
        end
        if (error_count == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("Simulation FAILED");
            $fatal(1, "coverage shortfall");
        end
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+dv
common/elevator_pkg.sv
requests/request_latch.sv
requests/request_queue.sv
logic/car_control.sv
logic/floor_logic_top.sv
dv/floor_logic_tb.sv

/* run.sh */
#!/bin/sh
# Build the floor logic testbench with Verilator and run it.
# The run passes only if the simulation output holds the pass message.

verilator --binary --timing --assert --top-module floor_logic_tb -f tb.f \
    -o floor_logic_sim \
    && ./obj_dir/floor_logic_sim 2>&1 | tee /dev/stderr | grep -q "Simulation PASSED" \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
